// ==== video_display.f ====
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/frame_buffer.sv
hdl/pixel_fetch.sv
hdl/video_display.sv
bench/tb_video_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the VGA display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_video_display \
    -f video_display.f

sim_out=$(./obj_dir/Vtb_video_display 2>&1) || {
    echo "$sim_out"
    exit 1
}
echo "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

// ==== bench/tb_video_display.sv ====
// VGA display testbench
// Random buffer image checked against the scanned raster

`timescale 1ns/1ps

module tb_video_display;
    import video_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int reset_cycles = 16;
    localparam int frame_clocks = h_total * v_total;
    localparam int watchdog_ns = 3 * frame_clocks * clk_period_ns;
    localparam int unsigned rand_seed = 32'h974c1da3;

    // Sync high, all colors black
    localparam logic [1+3*color_width:0] idle_pins = {2'b11, {3*color_width{1'b0}}};

    logic clk_pixel = 1'b0;
    logic rstn_pixel;
    logic wr_en;
    logic [fb_addr_width-1:0] wr_addr;
    logic [fb_data_width-1:0] wr_data;
    logic vga_hsync;
    logic vga_vsync;
    logic [color_width-1:0] vga_red;
    logic [color_width-1:0] vga_green;
    logic [color_width-1:0] vga_blue;

    // Image as written into the DUT
    logic [fb_data_width-1:0] model_mem [fb_depth];

    // Raster position that the pins show in the current clock
    int tx = 0;
    int ty = 0;
    logic tracking = 1'b0;
    logic reset_applied = 1'b0;
    logic vsync_prev = 1'b0;
    int tracked_clocks = 0;

    video_display u_dut (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

    always #(clk_period_ns / 2) clk_pixel = ~clk_pixel;

    // ##############################
    // Expected pin values
    // ##############################

    function automatic logic hsync_level(input int x);
        logic in_pulse;
        in_pulse = (x >= h_active + h_front) && (x < h_active + h_front + h_sync);
        return in_pulse ? h_sync_pol : ~h_sync_pol;
    endfunction

    function automatic logic vsync_level(input int y);
        logic in_pulse;
        in_pulse = (y >= v_active + v_front) && (y < v_active + v_front + v_sync);
        return in_pulse ? v_sync_pol : ~v_sync_pol;
    endfunction

    function automatic logic in_picture(input int x, input int y);
        return (x < h_active) && (y < v_active);
    endfunction

    // Each buffer word covers a 2x2 screen block
    function automatic logic [fb_data_width-1:0] model_word(input int x, input int y);
        int index;
        index = (y >> scale_shift) * fb_width + (x >> scale_shift);
        return model_mem[fb_addr_width'(index)];
    endfunction

    function automatic logic [color_width-1:0] red_nibble(input int x, input int y);
        logic [fb_data_width-1:0] word;
        word = model_word(x, y);
        return word[color_width-1:0];
    endfunction

    function automatic logic [color_width-1:0] green_nibble(input int x, input int y);
        logic [fb_data_width-1:0] word;
        word = model_word(x, y);
        return word[2*color_width-1:color_width];
    endfunction

    function automatic logic [color_width-1:0] blue_nibble(input int x, input int y);
        logic [fb_data_width-1:0] word;
        word = model_word(x, y);
        return word[3*color_width-1:2*color_width];
    endfunction

    task automatic value_mismatch(input string check_name, input int expected, input int actual);
        $display("Error: %s expected %0h actual %0h", check_name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "Check %s failed", check_name);
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        int word_index;
        logic [fb_data_width-1:0] word;
        rstn_pixel <= 1'b0;
        wr_en <= 1'b0;
        wr_addr <= '0;
        wr_data <= '0;
        void'($urandom(rand_seed));
        repeat (reset_cycles) @(posedge clk_pixel);
        rstn_pixel <= 1'b1;
        // One random word per clock, done long before line 490
        for (word_index = 0; word_index < fb_depth; word_index++) begin
            @(posedge clk_pixel);
            word = fb_data_width'($urandom);
            model_mem[fb_addr_width'(word_index)] = word;
            wr_en <= 1'b1;
            wr_addr <= fb_addr_width'(word_index);
            wr_data <= word;
        end
        @(posedge clk_pixel);
        wr_en <= 1'b0;
        wait (tracked_clocks >= 2 * frame_clocks);
        @(posedge clk_pixel);
        $display("STATUS: PASS");
        $finish;
    end

    // ##############################
    // Raster tracking
    // ##############################

    always @(posedge clk_pixel) begin
        vsync_prev <= vga_vsync;
        if (!rstn_pixel) begin
            reset_applied <= 1'b1;
        end
        if (tracking) begin
            tracked_clocks <= tracked_clocks + 1;
            if (tx == h_total - 1) begin
                tx <= 0;
                ty <= (ty == v_total - 1) ? 0 : ty + 1;
            end else begin
                tx <= tx + 1;
            end
        end else if (reset_applied && rstn_pixel && vsync_prev && !vga_vsync) begin
            // This edge saw x 0 of line 490, so the next one sees x 1
            tracking <= 1'b1;
            tx <= 1;
            ty <= v_active + v_front;
        end
    end

    // ##############################
    // Checks
    // ##############################

    a_reset_idle: assert property (@(posedge clk_pixel)
        reset_applied && !rstn_pixel |->
            {vga_hsync, vga_vsync, vga_blue, vga_green, vga_red} == idle_pins)
        else value_mismatch("reset_idle", int'(idle_pins),
            int'($sampled({vga_hsync, vga_vsync, vga_blue, vga_green, vga_red})));

    a_hsync: assert property (@(posedge clk_pixel)
        tracking |-> vga_hsync == hsync_level(tx))
        else value_mismatch("hsync", int'(hsync_level($sampled(tx))),
            int'($sampled(vga_hsync)));

    a_vsync: assert property (@(posedge clk_pixel)
        tracking |-> vga_vsync == vsync_level(ty))
        else value_mismatch("vsync", int'(vsync_level($sampled(ty))),
            int'($sampled(vga_vsync)));

    a_blank: assert property (@(posedge clk_pixel)
        tracking && !in_picture(tx, ty) |-> {vga_blue, vga_green, vga_red} == '0)
        else value_mismatch("blank", 0,
            int'($sampled({vga_blue, vga_green, vga_red})));

    a_red: assert property (@(posedge clk_pixel)
        tracking && in_picture(tx, ty) |-> vga_red == red_nibble(tx, ty))
        else value_mismatch("pixel_red", int'(red_nibble($sampled(tx), $sampled(ty))),
            int'($sampled(vga_red)));

    a_green: assert property (@(posedge clk_pixel)
        tracking && in_picture(tx, ty) |-> vga_green == green_nibble(tx, ty))
        else value_mismatch("pixel_green", int'(green_nibble($sampled(tx), $sampled(ty))),
            int'($sampled(vga_green)));

    a_blue: assert property (@(posedge clk_pixel)
        tracking && in_picture(tx, ty) |-> vga_blue == blue_nibble(tx, ty))
        else value_mismatch("pixel_blue", int'(blue_nibble($sampled(tx), $sampled(ty))),
            int'($sampled(vga_blue)));

    // Three frame times cover reset, the fill and two tracked frames
    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish two tracked frames in time");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== hdl/video_display.sv ====
// VGA display top level
// Timing, frame buffer and fetch stage

`timescale 1ns/1ps

module video_display (
    input  logic                                clk_pixel,
    input  logic                                rstn_pixel,
    input  logic                                wr_en,
    input  logic [video_pkg::fb_addr_width-1:0] wr_addr,
    input  logic [video_pkg::fb_data_width-1:0] wr_data,
    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic [video_pkg::color_width-1:0]   vga_red,
    output logic [video_pkg::color_width-1:0]   vga_green,
    output logic [video_pkg::color_width-1:0]   vga_blue
);
    import video_pkg::*;

    // Raster state for the current clock
    logic [x_width-1:0] pos_x;
    logic [y_width-1:0] pos_y;
    logic hsync_raw;
    logic vsync_raw;
    logic active;

    // Memory read path
    logic [fb_addr_width-1:0] rd_addr;
    logic [fb_data_width-1:0] rd_data;

    video_timing u_timing (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .active     (active)
    );

    frame_buffer u_buffer (
        .clk_pixel (clk_pixel),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // Two clocks from raster position to pins
    pixel_fetch u_fetch (
        .clk_pixel  (clk_pixel),
        .rstn_pixel (rstn_pixel),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .active     (active),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync),
        .vga_red    (vga_red),
        .vga_green  (vga_green),
        .vga_blue   (vga_blue)
    );

endmodule

// ==== hdl/pixel_fetch.sv ====
// Pixel fetch and output stage
// Buffer address, pipeline alignment, color split

`timescale 1ns/1ps

module pixel_fetch (
    input  logic                                 clk_pixel,
    input  logic                                 rstn_pixel,
    input  logic [video_pkg::x_width-1:0]        pos_x,
    input  logic [video_pkg::y_width-1:0]        pos_y,
    input  logic                                 hsync_raw,
    input  logic                                 vsync_raw,
    input  logic                                 active,
    output logic [video_pkg::fb_addr_width-1:0]  rd_addr,
    input  logic [video_pkg::fb_data_width-1:0]  rd_data,
    output logic                                 vga_hsync,
    output logic                                 vga_vsync,
    output logic [video_pkg::color_width-1:0]    vga_red,
    output logic [video_pkg::color_width-1:0]    vga_green,
    output logic [video_pkg::color_width-1:0]    vga_blue
);
    import video_pkg::*;

    logic [fb_addr_width-1:0] fb_col;
    logic [fb_addr_width-1:0] fb_row;
    logic [fb_addr_width-1:0] row_base;

    // Stage 1 levels, lined up with rd_data
    logic hsync_d1;
    logic vsync_d1;
    logic active_d1;

    logic [color_width-1:0] red_next;
    logic [color_width-1:0] green_next;
    logic [color_width-1:0] blue_next;

    // ##############################
    // Address generation
    // ##############################

    // Each buffer word covers a 2x2 block on screen
    assign fb_col = fb_addr_width'(pos_x >> scale_shift);
    assign fb_row = fb_addr_width'(pos_y >> scale_shift);
    assign row_base = fb_row * fb_addr_width'(fb_width);

    // Park on word zero during blanking
    assign rd_addr = active ? (row_base + fb_col) : '0;

    // ##############################
    // Stage 1 delay
    // ##############################

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            hsync_d1 <= ~h_sync_pol;
            vsync_d1 <= ~v_sync_pol;
            active_d1 <= 1'b0;
        end else begin
            hsync_d1 <= hsync_raw;
            vsync_d1 <= vsync_raw;
            active_d1 <= active;
        end
    end

    // Split the word, black outside the picture
    assign red_next = active_d1 ? rd_data[red_lsb +: color_width] : '0;
    assign green_next = active_d1 ? rd_data[green_lsb +: color_width] : '0;
    assign blue_next = active_d1 ? rd_data[blue_lsb +: color_width] : '0;

    // ##############################
    // Stage 2 output registers
    // ##############################

    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            vga_hsync <= ~h_sync_pol;
            vga_vsync <= ~v_sync_pol;
            vga_red <= '0;
            vga_green <= '0;
            vga_blue <= '0;
        end else begin
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
            vga_red <= red_next;
            vga_green <= green_next;
            vga_blue <= blue_next;
        end
    end

    // Blanked raster slot must reach the pins as black two clocks later
    a_blank_black: assert property (
        @(posedge clk_pixel) disable iff (!rstn_pixel)
        !$past(active, 2) |-> (vga_red == '0) && (vga_green == '0) && (vga_blue == '0)
    ) else $error("pixel_fetch: color %h%h%h during blanking",
                  vga_blue, vga_green, vga_red);

endmodule

// ==== hdl/frame_buffer.sv ====
// Frame buffer memory
// One write port, one registered read port

`timescale 1ns/1ps

module frame_buffer (
    input  logic                               clk_pixel,
    input  logic                               wr_en,
    input  logic [video_pkg::fb_addr_width-1:0] wr_addr,
    input  logic [video_pkg::fb_data_width-1:0] wr_data,
    input  logic [video_pkg::fb_addr_width-1:0] rd_addr,
    output logic [video_pkg::fb_data_width-1:0] rd_data
);
    import video_pkg::*;

    // One word per buffer pixel, row major
    logic [fb_data_width-1:0] mem [fb_depth];

    // ##############################
    // Write port
    // ##############################

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ##############################
    // Read port
    // ##############################

    // Data shows up one clock after the address
    always_ff @(posedge clk_pixel) begin
        rd_data <= mem[rd_addr];
    end

    // Writer must stay inside the 320x240 image
    a_wr_range: assert property (
        @(posedge clk_pixel)
        wr_en |-> (wr_addr < fb_addr_width'(fb_depth))
    ) else $error("frame_buffer: write address %0d beyond depth", wr_addr);

endmodule

// ==== hdl/video_timing.sv ====
// Raster timing generator
// Scan counters, sync and data enable

`timescale 1ns/1ps

module video_timing (
    input  logic                         clk_pixel,
    input  logic                         rstn_pixel,
    output logic [video_pkg::x_width-1:0] pos_x,
    output logic [video_pkg::y_width-1:0] pos_y,
    output logic                         hsync_raw,
    output logic                         vsync_raw,
    output logic                         active
);
    import video_pkg::*;

    logic line_end;
    logic frame_end;
    logic hsync_on;
    logic vsync_on;

    // ##############################
    // Raster counters
    // ##############################

    assign line_end = (pos_x == x_width'(h_total - 1));
    assign frame_end = (pos_y == y_width'(v_total - 1));

    // x runs every clock, y steps once per line
    always_ff @(posedge clk_pixel or negedge rstn_pixel) begin
        if (!rstn_pixel) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (line_end) begin
            pos_x <= '0;
            if (frame_end) begin
                pos_y <= '0;
            end else begin
                pos_y <= pos_y + 1'b1;
            end
        end else begin
            pos_x <= pos_x + 1'b1;
        end
    end

    // ##############################
    // Sync and active decode
    // ##############################

    // Horizontal pulse covers x = 656 .. 751
    assign hsync_on = (pos_x >= x_width'(h_active + h_front))
                   && (pos_x < x_width'(h_active + h_front + h_sync));

    // Vertical pulse covers whole lines 490 and 491
    assign vsync_on = (pos_y >= y_width'(v_active + v_front))
                   && (pos_y < y_width'(v_active + v_front + v_sync));

    // Polarity from the mode table
    assign hsync_raw = h_sync_pol ? hsync_on : ~hsync_on;
    assign vsync_raw = v_sync_pol ? vsync_on : ~vsync_on;

    assign active = (pos_x < x_width'(h_active)) && (pos_y < y_width'(v_active));

    // ##############################
    // Checks
    // ##############################

    a_x_range: assert property (
        @(posedge clk_pixel) disable iff (!rstn_pixel)
        pos_x < x_width'(h_total)
    ) else $error("video_timing: pos_x %0d out of range", pos_x);

    a_y_range: assert property (
        @(posedge clk_pixel) disable iff (!rstn_pixel)
        pos_y < y_width'(v_total)
    ) else $error("video_timing: pos_y %0d out of range", pos_y);

    // A new line only starts after the last clock of the previous one
    a_y_step: assert property (
        @(posedge clk_pixel) disable iff (!rstn_pixel)
        (pos_y != $past(pos_y)) |-> ($past(pos_x) == x_width'(h_total - 1))
    ) else $error("video_timing: pos_y moved at x %0d", $past(pos_x));

endmodule

// ==== hdl/video_pkg.sv ====
// Video output constants
// 640x480 at 60 Hz mode with a 320x240 frame buffer

package video_pkg;

    // ##############################
    // Horizontal timing
    // ##############################

    localparam int h_active = 640;
    localparam int h_front = 16;
    localparam int h_sync = 96;
    localparam int h_back = 48;
    localparam int h_total = h_active + h_front + h_sync + h_back;

    // Zero means the sync pulse is driven low
    localparam bit h_sync_pol = 1'b0;

    // ##############################
    // Vertical timing
    // ##############################

    // Counted in lines
    localparam int v_active = 480;
    localparam int v_front = 10;
    localparam int v_sync = 2;
    localparam int v_back = 33;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    localparam bit v_sync_pol = 1'b0;

    // Raster counter widths, enough for 800 and 525
    localparam int x_width = 10;
    localparam int y_width = 10;

    // ##############################
    // Frame buffer geometry
    // ##############################

    localparam int fb_width = 320;
    localparam int fb_height = 240;
    localparam int fb_depth = fb_width * fb_height;
    localparam int fb_addr_width = 17;
    localparam int fb_data_width = 12;

    // Screen position >> scale_shift gives the buffer position
    localparam int scale_shift = 1;

    // Color word layout, red in the low nibble and blue on top
    localparam int color_width = 4;
    localparam int red_lsb = 0;
    localparam int green_lsb = 4;
    localparam int blue_lsb = 8;

endpackage
